/* design/mcu_ao_pkg.sv */
// always-on control block shared definitions
// apb bus types, register map and power sequencing encodings
package mcu_ao_pkg;

  localparam int ADDR_W      = 12;
  localparam int DATA_W      = 32;
  localparam int GPIO_W      = 8;
  // 0 cpu, 1 peripheral, 2 and 3 memory banks
  localparam int NUM_DOMAINS = 4;
  // gpio edges in the low bits, power done on top
  localparam int NUM_IRQ     = 9;

  // region offset width, region index sits just above it
  localparam int OFS_W = 8;

  localparam logic [ADDR_W-1:0] PWR_BASE  = 12'h000;
  localparam logic [ADDR_W-1:0] GPIO_BASE = 12'h100;
  localparam logic [ADDR_W-1:0] IRQ_BASE  = 12'h200;

  localparam logic [OFS_W-1:0] DOMAIN_CTRL_OFS   = 8'h00;
  localparam logic [OFS_W-1:0] DOMAIN_STATUS_OFS = 8'h40;
  localparam int               DOMAIN_STRIDE     = 4;

  localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 8'h00;
  localparam logic [OFS_W-1:0] GPIO_OE_OFS  = 8'h04;
  localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 8'h08;

  localparam logic [OFS_W-1:0] IRQ_PENDING_OFS = 8'h00;
  localparam logic [OFS_W-1:0] IRQ_ENABLE_OFS  = 8'h04;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic pwr_on;
    logic iso_en;
    logic rst_n;
    logic clk_en;
    logic retain;
  } pwr_ctrl_t;

  typedef enum logic [2:0] {
    ON         = 3'd0,
    GATE_CLK   = 3'd1,
    ISOLATE    = 3'd2,
    RESET      = 3'd3,
    SWITCH_OFF = 3'd4,
    OFF        = 3'd5,
    SWITCH_ON  = 3'd6,
    RELEASE    = 3'd7
  } pwr_state_e;

  // domain fully powered and running
  localparam pwr_ctrl_t PWR_CTRL_ON = '{
    pwr_on: 1'b1,
    iso_en: 1'b0,
    rst_n:  1'b1,
    clk_en: 1'b1,
    retain: 1'b0
  };

endpackage

/* design/apb_ao_decoder.sv */
// apb region decoder for the always-on block
// steers psel to power, gpio or irq and merges the responses
module apb_ao_decoder
  import mcu_ao_pkg::*;
(
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output apb_req_t pwr_req_o,
  output apb_req_t gpio_req_o,
  output apb_req_t irq_req_o,
  input  apb_rsp_t pwr_rsp_i,
  input  apb_rsp_t gpio_rsp_i,
  input  apb_rsp_t irq_rsp_i
);

  logic [1:0] region;
  logic       hit_pwr;
  logic       hit_gpio;
  logic       hit_irq;
  apb_req_t   local_req;

  assign region   = apb_req_i.paddr[OFS_W +: 2];
  assign hit_pwr  = region == PWR_BASE[OFS_W +: 2];
  assign hit_gpio = region == GPIO_BASE[OFS_W +: 2];
  assign hit_irq  = region == IRQ_BASE[OFS_W +: 2];

  always_comb begin
    // targets only see the offset inside their region
    local_req       = apb_req_i;
    local_req.paddr = ADDR_W'(apb_req_i.paddr[OFS_W-1:0]);

    pwr_req_o       = local_req;
    gpio_req_o      = local_req;
    irq_req_o       = local_req;
    pwr_req_o.psel  = apb_req_i.psel & hit_pwr;
    gpio_req_o.psel = apb_req_i.psel & hit_gpio;
    irq_req_o.psel  = apb_req_i.psel & hit_irq;

    if (hit_pwr) begin
      apb_rsp_o = pwr_rsp_i;
    end else if (hit_gpio) begin
      apb_rsp_o = gpio_rsp_i;
    end else if (hit_irq) begin
      apb_rsp_o = irq_rsp_i;
    end else begin
      // unmapped region answers with an error
      apb_rsp_o.prdata  = '0;
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = apb_req_i.psel & apb_req_i.penable;
    end
  end

endmodule

/* design/power_domain_seq.sv */
// power sequencer for a single domain
// orders clock gate, isolation, reset, retention and the power switch
module power_domain_seq
  import mcu_ao_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       on_req_i,
  input  logic       retain_req_i,
  input  logic       pwr_ack_i,
  output pwr_ctrl_t  ctrl_o,
  output pwr_state_e state_o,
  output logic       done_o
);

  pwr_state_e state_q;
  pwr_ctrl_t  ctrl_q;
  logic       done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ON;
      ctrl_q  <= PWR_CTRL_ON;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ON: begin
          if (!on_req_i) begin
            state_q       <= GATE_CLK;
            ctrl_q.clk_en <= 1'b0;
          end
        end
        GATE_CLK: begin
          state_q       <= ISOLATE;
          ctrl_q.iso_en <= 1'b1;
        end
        ISOLATE: begin
          state_q       <= RESET;
          ctrl_q.rst_n  <= 1'b0;
          ctrl_q.retain <= retain_req_i;
        end
        RESET: begin
          state_q       <= SWITCH_OFF;
          ctrl_q.pwr_on <= 1'b0;
        end
        SWITCH_OFF: begin
          // wait for the supply to actually drop
          if (!pwr_ack_i) begin
            state_q <= OFF;
            done_q  <= 1'b1;
          end
        end
        OFF: begin
          if (on_req_i) begin
            state_q       <= SWITCH_ON;
            ctrl_q.pwr_on <= 1'b1;
          end
        end
        SWITCH_ON: begin
          if (pwr_ack_i) begin
            state_q       <= RELEASE;
            ctrl_q.rst_n  <= 1'b1;
            ctrl_q.retain <= 1'b0;
          end
        end
        RELEASE: begin
          state_q       <= ON;
          ctrl_q.iso_en <= 1'b0;
          ctrl_q.clk_en <= 1'b1;
          done_q        <= 1'b1;
        end
        default: begin
          state_q <= ON;
          ctrl_q  <= PWR_CTRL_ON;
        end
      endcase
    end
  end

  assign ctrl_o  = ctrl_q;
  assign state_o = state_q;
  assign done_o  = done_q;

endmodule

/* design/power_manager.sv */
// power manager with per-domain control and status registers
// each domain is driven by its own sequencer
module power_manager
  import mcu_ao_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  apb_req_t                     apb_req_i,
  output apb_rsp_t                     apb_rsp_o,
  input  logic       [NUM_DOMAINS-1:0] pwr_ack_i,
  output pwr_ctrl_t  [NUM_DOMAINS-1:0] pwr_ctrl_o,
  output logic                         done_o
);

  logic       [OFS_W-1:0]       ofs;
  logic                         wr_en;
  logic       [NUM_DOMAINS-1:0] on_req_q;
  logic       [NUM_DOMAINS-1:0] ret_req_q;
  logic       [NUM_DOMAINS-1:0] ctrl_hit;
  logic       [NUM_DOMAINS-1:0] status_hit;
  logic       [NUM_DOMAINS-1:0] seq_done;
  pwr_state_e [NUM_DOMAINS-1:0] seq_state;

  assign ofs   = apb_req_i.paddr[OFS_W-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_domain
    assign ctrl_hit[i]   = ofs == DOMAIN_CTRL_OFS + OFS_W'(DOMAIN_STRIDE * i);
    assign status_hit[i] = ofs == DOMAIN_STATUS_OFS + OFS_W'(DOMAIN_STRIDE * i);

    power_domain_seq u_seq (
      .clk_i,
      .rst_n_i,
      .on_req_i    (on_req_q[i]),
      .retain_req_i(ret_req_q[i]),
      .pwr_ack_i   (pwr_ack_i[i]),
      .ctrl_o      (pwr_ctrl_o[i]),
      .state_o     (seq_state[i]),
      .done_o      (seq_done[i])
    );
  end

  // requests held here until the sequencer is idle again
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      on_req_q  <= '1;
      ret_req_q <= '0;
    end else begin
      for (int i = 0; i < NUM_DOMAINS; i++) begin
        if (wr_en && ctrl_hit[i]) begin
          on_req_q[i]  <= apb_req_i.pwdata[0];
          ret_req_q[i] <= apb_req_i.pwdata[1];
        end
      end
    end
  end

  always_comb begin
    apb_rsp_o.prdata = '0;
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      if (ctrl_hit[i]) begin
        apb_rsp_o.prdata = DATA_W'({ret_req_q[i], on_req_q[i]});
      end
      if (status_hit[i]) begin
        apb_rsp_o.prdata = DATA_W'(seq_state[i]);
      end
    end
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

  assign done_o = |seq_done;

endmodule

/* design/gpio_ao.sv */
// always-on gpio with output and enable registers
// synchronized inputs and rising-edge pulses
module gpio_ao
  import mcu_ao_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  apb_req_t          apb_req_i,
  output apb_rsp_t          apb_rsp_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o,
  output logic [GPIO_W-1:0] edge_o
);

  logic [OFS_W-1:0]  ofs;
  logic              wr_en;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] sync_q1;
  logic [GPIO_W-1:0] sync_q2;
  logic [GPIO_W-1:0] prev_q;

  assign ofs   = apb_req_i.paddr[OFS_W-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (wr_en) begin
      if (ofs == GPIO_OUT_OFS) out_q <= apb_req_i.pwdata[GPIO_W-1:0];
      if (ofs == GPIO_OE_OFS) oe_q <= apb_req_i.pwdata[GPIO_W-1:0];
    end
  end

  // two flop synchronizer plus one for the edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  assign edge_o    = sync_q2 & ~prev_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

  always_comb begin
    case (ofs)
      GPIO_OUT_OFS: apb_rsp_o.prdata = DATA_W'(out_q);
      GPIO_OE_OFS:  apb_rsp_o.prdata = DATA_W'(oe_q);
      GPIO_IN_OFS:  apb_rsp_o.prdata = DATA_W'(sync_q2);
      default:      apb_rsp_o.prdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

endmodule

/* design/irq_ctrl.sv */
// interrupt controller with pending and enable registers
// one registered interrupt line out
module irq_ctrl
  import mcu_ao_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  apb_req_t           apb_req_i,
  output apb_rsp_t           apb_rsp_o,
  input  logic [NUM_IRQ-1:0] src_i,
  output logic               irq_o
);

  logic [OFS_W-1:0]   ofs;
  logic               wr_en;
  logic [NUM_IRQ-1:0] pend_clr;
  logic [NUM_IRQ-1:0] pending_q;
  logic [NUM_IRQ-1:0] enable_q;
  logic               irq_q;

  assign ofs   = apb_req_i.paddr[OFS_W-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  // write one to clear
  assign pend_clr = (wr_en && ofs == IRQ_PENDING_OFS) ? apb_req_i.pwdata[NUM_IRQ-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      irq_q     <= 1'b0;
    end else begin
      // a new source pulse beats a clear in the same cycle
      pending_q <= (pending_q & ~pend_clr) | src_i;
      if (wr_en && ofs == IRQ_ENABLE_OFS) begin
        enable_q <= apb_req_i.pwdata[NUM_IRQ-1:0];
      end
      irq_q <= |(pending_q & enable_q);
    end
  end

  always_comb begin
    case (ofs)
      IRQ_PENDING_OFS: apb_rsp_o.prdata = DATA_W'(pending_q);
      IRQ_ENABLE_OFS:  apb_rsp_o.prdata = DATA_W'(enable_q);
      default:         apb_rsp_o.prdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

  assign irq_o = irq_q;

endmodule

/* design/mcu_ao_top.sv */
// always-on control block top level
// apb decoder, power manager, gpio and interrupt controller
module mcu_ao_top
  import mcu_ao_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  apb_req_t                    apb_req_i,
  output apb_rsp_t                    apb_rsp_o,
  input  logic      [GPIO_W-1:0]      gpio_i,
  output logic      [GPIO_W-1:0]      gpio_o,
  output logic      [GPIO_W-1:0]      gpio_oe_o,
  output pwr_ctrl_t [NUM_DOMAINS-1:0] pwr_ctrl_o,
  input  logic      [NUM_DOMAINS-1:0] pwr_ack_i,
  output logic                        irq_o
);

  apb_req_t          pwr_req;
  apb_rsp_t          pwr_rsp;
  apb_req_t          gpio_req;
  apb_rsp_t          gpio_rsp;
  apb_req_t          irq_req;
  apb_rsp_t          irq_rsp;
  logic [GPIO_W-1:0] gpio_edge;
  logic              pwr_done;

  apb_ao_decoder u_decoder (
    .apb_req_i,
    .apb_rsp_o,
    .pwr_req_o (pwr_req),
    .gpio_req_o(gpio_req),
    .irq_req_o (irq_req),
    .pwr_rsp_i (pwr_rsp),
    .gpio_rsp_i(gpio_rsp),
    .irq_rsp_i (irq_rsp)
  );

  power_manager u_power_manager (
    .clk_i,
    .rst_n_i,
    .apb_req_i (pwr_req),
    .apb_rsp_o (pwr_rsp),
    .pwr_ack_i,
    .pwr_ctrl_o,
    .done_o    (pwr_done)
  );

  gpio_ao u_gpio_ao (
    .clk_i,
    .rst_n_i,
    .apb_req_i(gpio_req),
    .apb_rsp_o(gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .edge_o   (gpio_edge)
  );

  // power done sits above the gpio edges
  irq_ctrl u_irq_ctrl (
    .clk_i,
    .rst_n_i,
    .apb_req_i(irq_req),
    .apb_rsp_o(irq_rsp),
    .src_i    ({pwr_done, gpio_edge}),
    .irq_o
  );

endmodule

/* tests/mcu_ao_checker.sv */
// protocol and power control assertions for the always-on block
// bound into the top level
module mcu_ao_checker
  import mcu_ao_pkg::*;
(
  input logic                        clk_i,
  input logic                        rst_n_i,
  input apb_req_t                    apb_req_i,
  input apb_rsp_t                    apb_rsp_i,
  input pwr_ctrl_t [NUM_DOMAINS-1:0] pwr_ctrl_i,
  input logic                        irq_i
);

  // access phase needs a setup phase in front
  penable_after_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> $past(apb_req_i.psel))
    else $error("penable high without a psel cycle before it");

  // error only with ready, and only in an access to the unmapped region
  slverr_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_rsp_i.pslverr |-> (apb_rsp_i.pready && apb_req_i.psel && apb_req_i.penable &&
                           apb_req_i.paddr[OFS_W +: 2] == 2'b11))
    else $error("pslverr high outside a ready access to the unmapped region");

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_domain
    off_is_clamped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !pwr_ctrl_i[d].pwr_on |-> (pwr_ctrl_i[d].iso_en && !pwr_ctrl_i[d].rst_n))
      else $error("domain %0d unpowered without isolation and reset", d);
  end

  irq_quiet_in_reset: assert property (@(posedge clk_i)
    (!rst_n_i && $past(!rst_n_i)) |-> !irq_i)
    else $error("irq_o high while reset is held");

endmodule

bind mcu_ao_top mcu_ao_checker u_checker (
  .clk_i,
  .rst_n_i,
  .apb_req_i,
  .apb_rsp_i (apb_rsp_o),
  .pwr_ctrl_i(pwr_ctrl_o),
  .irq_i     (irq_o)
);

/* tests/mcu_ao_tb.sv */
// testbench for the always-on control block
// table of apb accesses and pin checks against a random switch model
module mcu_ao_tb
  import mcu_ao_pkg::*;
();

  typedef enum {OP_WR, OP_RD, OP_POLL, OP_PINS, OP_PWR, OP_IRQ} op_e;

  typedef struct {
    string             name;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    int                gpio;
    logic [DATA_W-1:0] exp_data;
    logic              exp_err;
  } test_t;

  logic                        clk;
  logic                        rst_n;
  apb_req_t                    apb_req;
  apb_rsp_t                    apb_rsp;
  logic      [GPIO_W-1:0]      gpio_in;
  logic      [GPIO_W-1:0]      gpio_out;
  logic      [GPIO_W-1:0]      gpio_oe;
  pwr_ctrl_t [NUM_DOMAINS-1:0] pwr_ctrl;
  logic      [NUM_DOMAINS-1:0] pwr_ack;
  logic                        irq;
  test_t                       tests[$];
  int                          passed;
  int                          failed;
  logic                        table_ready;
  logic                        reported;

  mcu_ao_top u_dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .pwr_ctrl_o(pwr_ctrl),
    .pwr_ack_i (pwr_ack),
    .irq_o     (irq)
  );

  always #2 clk = ~clk;

  // power switch follows pwr_on after 1 to 5 cycles
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_switch
    logic        ack_q;
    logic        target;
    int unsigned delay;

    assign pwr_ack[d] = ack_q;

    initial begin
      ack_q = 1'b1;
      // supply stays up until the block leaves reset
      wait (rst_n === 1'b1);
      forever begin
        @(negedge clk);
        if (ack_q !== pwr_ctrl[d].pwr_on) begin
          target = pwr_ctrl[d].pwr_on;
          delay  = $urandom_range(5, 1);
          repeat (delay) @(posedge clk);
          ack_q <= target;
        end
      end
    end
  end

  task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic add_test(input string name, input op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input int gpio,
                          input logic [DATA_W-1:0] exp_data, input logic exp_err);
    test_t t;
    t = '{name, op, addr, wdata, gpio, exp_data, exp_err};
    tests.push_back(t);
  endtask

  task automatic run_test(input test_t t);
    logic [DATA_W-1:0] actual;
    logic              err;
    int                tries;
    logic              ok;
    actual = '0;
    err    = 1'b0;
    ok     = 1'b1;
    if (t.gpio >= 0) begin
      @(posedge clk);
      gpio_in <= GPIO_W'(t.gpio);
    end
    case (t.op)
      OP_WR: apb_access(1'b1, t.addr, t.wdata, actual, err);
      OP_RD: apb_access(1'b0, t.addr, t.wdata, actual, err);
      OP_POLL: begin
        apb_access(1'b0, t.addr, t.wdata, actual, err);
        tries = 1;
        while (actual !== t.exp_data && tries < 20) begin
          apb_access(1'b0, t.addr, t.wdata, actual, err);
          tries++;
        end
      end
      default: begin
        // pins settle within two cycles of the last access
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (t.op == OP_PINS) actual = DATA_W'({gpio_oe, gpio_out});
        if (t.op == OP_PWR) actual = DATA_W'(pwr_ctrl[t.addr[1:0]]);
        if (t.op == OP_IRQ) actual = DATA_W'(irq);
      end
    endcase
    if (t.op != OP_WR && actual !== t.exp_data) begin
      $display("error %s: expected %h, actual %h", t.name, t.exp_data, actual);
      ok = 1'b0;
    end
    if (err !== t.exp_err) begin
      $display("error %s: expected pslverr %0b, actual %0b", t.name, t.exp_err, err);
      ok = 1'b0;
    end
    if (ok) begin
      $display("ok %s", t.name);
      passed++;
    end else begin
      failed++;
    end
  endtask

  task automatic build_table();
    pwr_ctrl_t off_ret;
    pwr_ctrl_t on_ctrl;
    off_ret = '{pwr_on: 1'b0, iso_en: 1'b1, rst_n: 1'b0, clk_en: 1'b0, retain: 1'b1};
    on_ctrl = '{pwr_on: 1'b1, iso_en: 1'b0, rst_n: 1'b1, clk_en: 1'b1, retain: 1'b0};
    add_test("status d0 on", OP_RD, 12'h040, 32'h0, -1, DATA_W'(ON), 1'b0);
    add_test("status d1 on", OP_RD, 12'h044, 32'h0, -1, DATA_W'(ON), 1'b0);
    add_test("status d2 on", OP_RD, 12'h048, 32'h0, -1, DATA_W'(ON), 1'b0);
    add_test("status d3 on", OP_RD, 12'h04C, 32'h0, -1, DATA_W'(ON), 1'b0);
    add_test("pending empty", OP_RD, 12'h200, 32'h0, -1, 32'h0, 1'b0);
    add_test("irq idle", OP_IRQ, 12'h0, 32'h0, -1, 32'h0, 1'b0);
    add_test("gpio out write", OP_WR, 12'h100, 32'hA5, -1, 32'h0, 1'b0);
    add_test("gpio oe write", OP_WR, 12'h104, 32'h3C, -1, 32'h0, 1'b0);
    add_test("gpio out read", OP_RD, 12'h100, 32'h0, -1, 32'hA5, 1'b0);
    add_test("gpio oe read", OP_RD, 12'h104, 32'h0, -1, 32'h3C, 1'b0);
    add_test("gpio pins", OP_PINS, 12'h0, 32'h0, -1, 32'h3CA5, 1'b0);
    add_test("gpio in 81", OP_POLL, 12'h108, 32'h0, 8'h81, 32'h81, 1'b0);
    // rising edges on pins 0 and 7, nothing enabled
    add_test("edge pending", OP_RD, 12'h200, 32'h0, -1, 32'h081, 1'b0);
    add_test("edge irq masked", OP_IRQ, 12'h0, 32'h0, -1, 32'h0, 1'b0);
    add_test("pending clear all", OP_WR, 12'h200, 32'h1FF, -1, 32'h0, 1'b0);
    add_test("d2 off request", OP_WR, 12'h008, 32'h2, -1, 32'h0, 1'b0);
    add_test("d2 reach off", OP_POLL, 12'h048, 32'h0, -1, DATA_W'(OFF), 1'b0);
    add_test("d2 off controls", OP_PWR, 12'h2, 32'h0, -1, DATA_W'(off_ret), 1'b0);
    add_test("d2 on request", OP_WR, 12'h008, 32'h1, -1, 32'h0, 1'b0);
    add_test("d2 reach on", OP_POLL, 12'h048, 32'h0, -1, DATA_W'(ON), 1'b0);
    add_test("d2 on controls", OP_PWR, 12'h2, 32'h0, -1, DATA_W'(on_ctrl), 1'b0);
    add_test("d2 done clear", OP_WR, 12'h200, 32'h100, -1, 32'h0, 1'b0);
    add_test("enable done", OP_WR, 12'h204, 32'h100, -1, 32'h0, 1'b0);
    add_test("d3 off request", OP_WR, 12'h00C, 32'h0, -1, 32'h0, 1'b0);
    add_test("d3 reach off", OP_POLL, 12'h04C, 32'h0, -1, DATA_W'(OFF), 1'b0);
    add_test("d3 done pending", OP_RD, 12'h200, 32'h0, -1, 32'h100, 1'b0);
    add_test("done irq high", OP_IRQ, 12'h0, 32'h0, -1, 32'h1, 1'b0);
    add_test("d3 done clear", OP_WR, 12'h200, 32'h100, -1, 32'h0, 1'b0);
    add_test("done irq low", OP_IRQ, 12'h0, 32'h0, -1, 32'h0, 1'b0);
    add_test("gpio in 85", OP_POLL, 12'h108, 32'h0, 8'h85, 32'h85, 1'b0);
    add_test("pin 2 pending", OP_RD, 12'h200, 32'h0, -1, 32'h004, 1'b0);
    add_test("pin 2 irq masked", OP_IRQ, 12'h0, 32'h0, -1, 32'h0, 1'b0);
    // unmapped region, offsets alias real registers
    add_test("region 3 write", OP_WR, 12'h300, 32'hFFFF_FFFF, -1, 32'h0, 1'b1);
    add_test("region 3 read", OP_RD, 12'h304, 32'h0, -1, 32'h0, 1'b1);
    add_test("gpio out kept", OP_RD, 12'h100, 32'h0, -1, 32'hA5, 1'b0);
    add_test("pending kept", OP_RD, 12'h200, 32'h0, -1, 32'h004, 1'b0);
    add_test("d0 ctrl kept", OP_RD, 12'h000, 32'h0, -1, 32'h1, 1'b0);
  endtask

  initial begin
    wait (table_ready);
    repeat (tests.size() * 40) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", tests.size() * 40);
    reported = 1'b1;
    $display("Something failed");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    apb_req     = '0;
    gpio_in     = '0;
    passed      = 0;
    failed      = 0;
    reported    = 1'b0;
    table_ready = 1'b0;
    void'($urandom(46558));
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tests[i]) run_test(tests[i]);
    repeat (4) @(posedge clk);
    $display("%0d tests, %0d passed, %0d failed", tests.size(), passed, failed);
    reported = 1'b1;
    if (failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // run stopped early by a failed assertion
  final begin
    if (!reported) $display("Something failed");
  end

endmodule

/* mcu_ao.f */
design/mcu_ao_pkg.sv
design/apb_ao_decoder.sv
design/power_domain_seq.sv
design/power_manager.sv
design/gpio_ao.sv
design/irq_ctrl.sv
design/mcu_ao_top.sv
tests/mcu_ao_checker.sv
tests/mcu_ao_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the always-on block testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module mcu_ao_tb -f mcu_ao.f -o sim_mcu_ao
./obj_dir/sim_mcu_ao > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
